// File: Makefile
# Verilator build and run of the decode to execute testbench

BUILD := obj_dir
LOG   := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_decode_execute -Mdir $(BUILD) -f filelist.f
	./$(BUILD)/Vtb_decode_execute | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: common/mips_pkg.sv
// ------------------------------------------------
// mips shared definitions
// widths, opcode and funct encodings, control
// selector codes and the alu function enum
// ------------------------------------------------
`default_nettype none

package mips_pkg;

	// field widths with a meaning
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  funct_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [1:0]  alu_op_t;
	typedef logic [1:0]  sel2_t;

	// alu functions, 4 bits leaves room for shifts later
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_SLT = 4'd4
	} alu_fn_e;

	// opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_J     = 6'h02;
	localparam opcode_t OP_JAL   = 6'h03;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;

	// r-type funct
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_SLT = 6'h2a;

	// alu_op classes, 11 is reserved and acts as add
	localparam alu_op_t ALU_OP_ADD   = 2'b00;
	localparam alu_op_t ALU_OP_SUB   = 2'b01;
	localparam alu_op_t ALU_OP_FUNCT = 2'b10;

	// reg_dst codes
	localparam sel2_t REG_DST_RT = 2'b00;
	localparam sel2_t REG_DST_RD = 2'b01;
	localparam sel2_t REG_DST_RA = 2'b10;

	// mem_to_reg codes
	localparam sel2_t MEM_TO_REG_ALU = 2'b00;
	localparam sel2_t MEM_TO_REG_MEM = 2'b01;
	localparam sel2_t MEM_TO_REG_PC4 = 2'b10;

	// link register for jal
	localparam reg_addr_t REG_RA = 5'd31;

endpackage

`default_nettype wire

// File: decode/control_unit.sv
// ------------------------------------------------
// main control decoder
// maps the opcode onto the write-back, memory and
// execute control fields of the pipeline
// ------------------------------------------------
`default_nettype none

module control_unit (
	input  mips_pkg::opcode_t opcode,
	output logic              reg_write,
	output logic              mem_read,
	output logic              mem_write,
	output logic              branch,
	output logic              jump,
	output logic              alu_src,
	output mips_pkg::alu_op_t alu_op,
	output mips_pkg::sel2_t   reg_dst,
	output mips_pkg::sel2_t   mem_to_reg
);

	always_comb begin
		// all-zero controls unless the opcode is known
		reg_write  = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		branch     = 1'b0;
		jump       = 1'b0;
		alu_src    = 1'b0;
		alu_op     = mips_pkg::ALU_OP_ADD;
		reg_dst    = mips_pkg::REG_DST_RT;
		mem_to_reg = mips_pkg::MEM_TO_REG_ALU;

		case (opcode)
			mips_pkg::OP_RTYPE: begin
				// funct picks the operation, result to rd
				reg_write = 1'b1;
				alu_op    = mips_pkg::ALU_OP_FUNCT;
				reg_dst   = mips_pkg::REG_DST_RD;
			end
			mips_pkg::OP_ADDI: begin
				reg_write = 1'b1;
				alu_src   = 1'b1;
			end
			mips_pkg::OP_LW: begin
				// address = rs + imm, data back into rt
				reg_write  = 1'b1;
				mem_read   = 1'b1;
				alu_src    = 1'b1;
				mem_to_reg = mips_pkg::MEM_TO_REG_MEM;
			end
			mips_pkg::OP_SW: begin
				mem_write = 1'b1;
				alu_src   = 1'b1;
			end
			mips_pkg::OP_BEQ: begin
				// compare by subtraction, zero flag decides
				branch = 1'b1;
				alu_op = mips_pkg::ALU_OP_SUB;
			end
			mips_pkg::OP_J: begin
				jump = 1'b1;
			end
			mips_pkg::OP_JAL: begin
				// link pc+4 into r31
				jump       = 1'b1;
				reg_write  = 1'b1;
				reg_dst    = mips_pkg::REG_DST_RA;
				mem_to_reg = mips_pkg::MEM_TO_REG_PC4;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: decode/hazard_unit.sv
// ------------------------------------------------
// load-use hazard detection
// stalls the decoding instruction one cycle when
// the load in id/ex writes one of its sources
// ------------------------------------------------
`default_nettype none

module hazard_unit (
	input  mips_pkg::reg_addr_t if_id_rs,
	input  mips_pkg::reg_addr_t if_id_rt,
	input  mips_pkg::reg_addr_t id_ex_rt,
	input  wire                 id_ex_mem_read,
	output logic                stall
);

	logic rs_match;
	logic rt_match;

	// r0 is never a real dependency
	assign rs_match = (id_ex_rt == if_id_rs);
	assign rt_match = (id_ex_rt == if_id_rt);

	// conservative, rt counts even if only a destination
	assign stall = id_ex_mem_read && (id_ex_rt != '0) && (rs_match || rt_match);

	always_comb begin
		// only a load in id/ex may hold up decode
		a_stall_load: assert #0 (!stall || id_ex_mem_read);
	end

endmodule

`default_nettype wire

// File: decode/register_file.sv
// ------------------------------------------------
// general purpose register file
// two combinational read ports, one write port with
// bypass into the reads, register 0 reads as zero
// ------------------------------------------------
`default_nettype none

module register_file #(
	parameter int REG_COUNT = 32
) (
	input  wire                 clk,
	input  wire                 rst,
	input  mips_pkg::reg_addr_t rs,
	input  mips_pkg::reg_addr_t rt,
	output mips_pkg::word_t     rs_data,
	output mips_pkg::word_t     rt_data,
	input  wire                 we,
	input  mips_pkg::reg_addr_t wd_addr,
	input  mips_pkg::word_t     wd
);

	mips_pkg::word_t regs [REG_COUNT];

	// one read port, shared by rs and rt
	function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t addr);
		mips_pkg::word_t value;
		if (addr == '0 || int'(addr) >= REG_COUNT)
			value = '0;
		else if (we && wd_addr == addr)
			// write in flight this cycle
			value = wd;
		else
			value = regs[addr];
		return value;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we && wd_addr != '0 && int'(wd_addr) < REG_COUNT) begin
			regs[wd_addr] <= wd;
		end
	end

	always_comb begin
		rs_data = read_port(rs);
		rt_data = read_port(rt);
	end

	// r0 stays zero even with a write to it on the port
	a_zero_reg: assert property (@(posedge clk) disable iff (rst)
		(rs != '0 || rs_data == '0) && (rt != '0 || rt_data == '0));

endmodule

`default_nettype wire

// File: execute/execute_unit.sv
// ------------------------------------------------
// execute stage datapath
// alu control and alu, branch target adder and the
// destination register mux
// ------------------------------------------------
`default_nettype none

module execute_unit (
	input  mips_pkg::alu_op_t   alu_op,
	input  mips_pkg::funct_t    funct,
	input  wire                 alu_src,
	input  mips_pkg::word_t     rs_data,
	input  mips_pkg::word_t     rt_data,
	input  mips_pkg::word_t     imm,
	input  mips_pkg::word_t     pc_plus4,
	input  mips_pkg::reg_addr_t rt,
	input  mips_pkg::reg_addr_t rd,
	input  mips_pkg::sel2_t     reg_dst,
	output mips_pkg::word_t     alu_result,
	output mips_pkg::word_t     branch_addr,
	output logic                zero,
	output mips_pkg::reg_addr_t write_reg
);

	mips_pkg::alu_fn_e alu_fn;
	mips_pkg::word_t   operand_b;

	// alu control
	always_comb begin
		case (alu_op)
			mips_pkg::ALU_OP_SUB: alu_fn = mips_pkg::ALU_SUB;
			mips_pkg::ALU_OP_FUNCT: begin
				case (funct)
					mips_pkg::FN_ADD: alu_fn = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB: alu_fn = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_fn = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:  alu_fn = mips_pkg::ALU_OR;
					mips_pkg::FN_SLT: alu_fn = mips_pkg::ALU_SLT;
					default:          alu_fn = mips_pkg::ALU_ADD;
				endcase
			end
			// add class and the reserved code
			default: alu_fn = mips_pkg::ALU_ADD;
		endcase
	end

	// immediate for addi, lw, sw
	assign operand_b = alu_src ? imm : rt_data;

	always_comb begin
		case (alu_fn)
			mips_pkg::ALU_SUB: alu_result = rs_data - operand_b;
			mips_pkg::ALU_AND: alu_result = rs_data & operand_b;
			mips_pkg::ALU_OR:  alu_result = rs_data | operand_b;
			// signed compare
			mips_pkg::ALU_SLT: alu_result = {31'b0, $signed(rs_data) < $signed(operand_b)};
			default:           alu_result = rs_data + operand_b;
		endcase
	end

	assign zero = (alu_result == '0);

	// word offset relative to pc+4
	assign branch_addr = pc_plus4 + {imm[29:0], 2'b00};

	always_comb begin
		case (reg_dst)
			mips_pkg::REG_DST_RD: write_reg = rd;
			mips_pkg::REG_DST_RA: write_reg = mips_pkg::REG_RA;
			default:              write_reg = rt;
		endcase
	end

	always_comb begin
		// funct decoder falls back to add, never an unlisted code
		a_alu_fn: assert #0 (alu_fn inside {mips_pkg::ALU_ADD, mips_pkg::ALU_SUB,
			mips_pkg::ALU_AND, mips_pkg::ALU_OR, mips_pkg::ALU_SLT});
	end

endmodule

`default_nettype wire

// File: filelist.f
common/mips_pkg.sv
decode/control_unit.sv
decode/register_file.sv
decode/hazard_unit.sv
logic/id_ex.sv
execute/execute_unit.sv
logic/decode_execute.sv
verification/tb_decode_execute.sv

// File: logic/decode_execute.sv
// ------------------------------------------------
// decode to execute pipeline slice
// decode, register read and hazard check, the id/ex
// register and the execute stage datapath
// ------------------------------------------------
`default_nettype none

module decode_execute #(
	parameter int REG_COUNT = 32
) (
	input  wire                  clk,
	input  wire                  rst,
	// if/id contents
	input  mips_pkg::word_t      instr,
	input  mips_pkg::word_t      pc_plus4,
	input  wire                  branch_flush,
	// write-back port
	input  wire                  wb_reg_write,
	input  mips_pkg::reg_addr_t  wb_rd,
	input  mips_pkg::word_t      wb_data,
	output logic                 stall,
	// execute stage view
	output logic                 ex_reg_write,
	output mips_pkg::sel2_t      ex_mem_to_reg,
	output logic                 ex_mem_read,
	output logic                 ex_mem_write,
	output logic                 ex_branch,
	output logic                 ex_jump,
	output mips_pkg::word_t      ex_alu_result,
	output logic                 ex_zero,
	output mips_pkg::reg_addr_t  ex_write_reg,
	output mips_pkg::word_t      ex_store_data,
	output mips_pkg::word_t      ex_branch_addr,
	output mips_pkg::word_t      ex_jump_addr,
	output mips_pkg::word_t      ex_pc_plus4
);

	// instruction fields
	mips_pkg::opcode_t   id_opcode;
	mips_pkg::reg_addr_t id_rs;
	mips_pkg::reg_addr_t id_rt;
	mips_pkg::reg_addr_t id_rd;
	mips_pkg::funct_t    id_funct;
	mips_pkg::word_t     id_imm;
	mips_pkg::word_t     id_jump_addr;

	// decoded controls and operands
	logic                id_reg_write;
	logic                id_mem_read;
	logic                id_mem_write;
	logic                id_branch;
	logic                id_jump;
	logic                id_alu_src;
	mips_pkg::alu_op_t   id_alu_op;
	mips_pkg::sel2_t     id_reg_dst;
	mips_pkg::sel2_t     id_mem_to_reg;
	mips_pkg::word_t     id_rs_data;
	mips_pkg::word_t     id_rt_data;

	// id/ex outputs used only inside the slice
	logic                idex_alu_src;
	mips_pkg::alu_op_t   idex_alu_op;
	mips_pkg::sel2_t     idex_reg_dst;
	mips_pkg::word_t     idex_rs_data;
	mips_pkg::word_t     idex_imm;
	mips_pkg::reg_addr_t idex_rt;
	mips_pkg::reg_addr_t idex_rd;
	mips_pkg::funct_t    idex_funct;

	assign id_opcode = instr[31:26];
	assign id_rs     = instr[25:21];
	assign id_rt     = instr[20:16];
	assign id_rd     = instr[15:11];
	assign id_funct  = instr[5:0];
	// sign extend imm16
	assign id_imm    = {{16{instr[15]}}, instr[15:0]};
	// pseudo-direct jump target
	assign id_jump_addr = {pc_plus4[31:28], instr[25:0], 2'b00};

	control_unit i_control_unit (
		.opcode     (id_opcode),
		.reg_write  (id_reg_write),
		.mem_read   (id_mem_read),
		.mem_write  (id_mem_write),
		.branch     (id_branch),
		.jump       (id_jump),
		.alu_src    (id_alu_src),
		.alu_op     (id_alu_op),
		.reg_dst    (id_reg_dst),
		.mem_to_reg (id_mem_to_reg)
	);

	register_file #(
		.REG_COUNT (REG_COUNT)
	) i_register_file (
		.clk     (clk),
		.rst     (rst),
		.rs      (id_rs),
		.rt      (id_rt),
		.rs_data (id_rs_data),
		.rt_data (id_rt_data),
		.we      (wb_reg_write),
		.wd_addr (wb_rd),
		.wd      (wb_data)
	);

	hazard_unit i_hazard_unit (
		.if_id_rs       (id_rs),
		.if_id_rt       (id_rt),
		.id_ex_rt       (idex_rt),
		.id_ex_mem_read (ex_mem_read),
		.stall          (stall)
	);

	id_ex i_id_ex (
		.clk            (clk),
		.rst            (rst),
		.stall          (stall),
		.flush          (branch_flush),
		.reg_write_in   (id_reg_write),
		.mem_to_reg_in  (id_mem_to_reg),
		.reg_write_out  (ex_reg_write),
		.mem_to_reg_out (ex_mem_to_reg),
		.branch_in      (id_branch),
		.mem_read_in    (id_mem_read),
		.mem_write_in   (id_mem_write),
		.jump_in        (id_jump),
		.branch_out     (ex_branch),
		.mem_read_out   (ex_mem_read),
		.mem_write_out  (ex_mem_write),
		.jump_out       (ex_jump),
		.reg_dst_in     (id_reg_dst),
		.alu_src_in     (id_alu_src),
		.alu_op_in      (id_alu_op),
		.reg_dst_out    (idex_reg_dst),
		.alu_src_out    (idex_alu_src),
		.alu_op_out     (idex_alu_op),
		.jump_addr_in   (id_jump_addr),
		.pc_plus4_in    (pc_plus4),
		.jump_addr_out  (ex_jump_addr),
		.pc_plus4_out   (ex_pc_plus4),
		.rs_data_in     (id_rs_data),
		.rt_data_in     (id_rt_data),
		.imm_in         (id_imm),
		.rs_data_out    (idex_rs_data),
		.rt_data_out    (ex_store_data),
		.imm_out        (idex_imm),
		.rs_in          (id_rs),
		.rt_in          (id_rt),
		.rd_in          (id_rd),
		.funct_in       (id_funct),
		// rs index is for a forwarding unit not in this slice
		.rs_out         (),
		.rt_out         (idex_rt),
		.rd_out         (idex_rd),
		.funct_out      (idex_funct)
	);

	execute_unit i_execute_unit (
		.alu_op      (idex_alu_op),
		.funct       (idex_funct),
		.alu_src     (idex_alu_src),
		.rs_data     (idex_rs_data),
		.rt_data     (ex_store_data),
		.imm         (idex_imm),
		.pc_plus4    (ex_pc_plus4),
		.rt          (idex_rt),
		.rd          (idex_rd),
		.reg_dst     (idex_reg_dst),
		.alu_result  (ex_alu_result),
		.branch_addr (ex_branch_addr),
		.zero        (ex_zero),
		.write_reg   (ex_write_reg)
	);

endmodule

`default_nettype wire

// File: logic/id_ex.sv
// ------------------------------------------------
// id/ex pipeline register
// captures decode results on the rising edge, and
// turns the control group into a bubble on a stall
// or branch flush, data fields always pass
// ------------------------------------------------
`default_nettype none

module id_ex (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 stall,
	input  wire                 flush,
	// wb control
	input  wire                 reg_write_in,
	input  mips_pkg::sel2_t     mem_to_reg_in,
	output logic                reg_write_out,
	output mips_pkg::sel2_t     mem_to_reg_out,
	// mem control
	input  wire                 branch_in,
	input  wire                 mem_read_in,
	input  wire                 mem_write_in,
	input  wire                 jump_in,
	output logic                branch_out,
	output logic                mem_read_out,
	output logic                mem_write_out,
	output logic                jump_out,
	// ex control
	input  mips_pkg::sel2_t     reg_dst_in,
	input  wire                 alu_src_in,
	input  mips_pkg::alu_op_t   alu_op_in,
	output mips_pkg::sel2_t     reg_dst_out,
	output logic                alu_src_out,
	output mips_pkg::alu_op_t   alu_op_out,
	// addresses
	input  mips_pkg::word_t     jump_addr_in,
	input  mips_pkg::word_t     pc_plus4_in,
	output mips_pkg::word_t     jump_addr_out,
	output mips_pkg::word_t     pc_plus4_out,
	// operands
	input  mips_pkg::word_t     rs_data_in,
	input  mips_pkg::word_t     rt_data_in,
	input  mips_pkg::word_t     imm_in,
	output mips_pkg::word_t     rs_data_out,
	output mips_pkg::word_t     rt_data_out,
	output mips_pkg::word_t     imm_out,
	// register indices and funct
	input  mips_pkg::reg_addr_t rs_in,
	input  mips_pkg::reg_addr_t rt_in,
	input  mips_pkg::reg_addr_t rd_in,
	input  mips_pkg::funct_t    funct_in,
	output mips_pkg::reg_addr_t rs_out,
	output mips_pkg::reg_addr_t rt_out,
	output mips_pkg::reg_addr_t rd_out,
	output mips_pkg::funct_t    funct_out
);

	logic bubble;

	assign bubble = stall || flush;

	// control group, zeroed on reset or bubble
	always_ff @(posedge clk) begin
		if (rst || bubble) begin
			reg_write_out  <= 1'b0;
			mem_to_reg_out <= '0;
			branch_out     <= 1'b0;
			mem_read_out   <= 1'b0;
			mem_write_out  <= 1'b0;
			jump_out       <= 1'b0;
			reg_dst_out    <= '0;
			alu_src_out    <= 1'b0;
			alu_op_out     <= '0;
		end else begin
			reg_write_out  <= reg_write_in;
			mem_to_reg_out <= mem_to_reg_in;
			branch_out     <= branch_in;
			mem_read_out   <= mem_read_in;
			mem_write_out  <= mem_write_in;
			jump_out       <= jump_in;
			reg_dst_out    <= reg_dst_in;
			alu_src_out    <= alu_src_in;
			alu_op_out     <= alu_op_in;
		end
	end

	// data group, only reset clears it
	always_ff @(posedge clk) begin
		if (rst) begin
			jump_addr_out <= '0;
			pc_plus4_out  <= '0;
			rs_data_out   <= '0;
			rt_data_out   <= '0;
			imm_out       <= '0;
			rs_out        <= '0;
			rt_out        <= '0;
			rd_out        <= '0;
			funct_out     <= '0;
		end else begin
			jump_addr_out <= jump_addr_in;
			pc_plus4_out  <= pc_plus4_in;
			rs_data_out   <= rs_data_in;
			rt_data_out   <= rt_data_in;
			imm_out       <= imm_in;
			rs_out        <= rs_in;
			rt_out        <= rt_in;
			rd_out        <= rd_in;
			funct_out     <= funct_in;
		end
	end

	// a bubble must not write, touch memory or redirect
	a_bubble: assert property (@(posedge clk) disable iff (rst)
		bubble |=> !(reg_write_out || mem_read_out || mem_write_out
			|| branch_out || jump_out));

endmodule

`default_nettype wire

// File: verification/tb_decode_execute.sv
// --------------------------------------------------
// testbench for the decode to execute slice
// drives instructions through the if/id inputs, keeps
// a register model and checks every ex_ output one
// cycle after issue with concurrent assertions
// --------------------------------------------------
`default_nettype none

module tb_decode_execute;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 400;
	// add r0, r0, r0
	localparam mips_pkg::word_t NOP = 32'h0000_0020;

	// expected id/ex view of one presented instruction
	typedef struct packed {
		logic                valid;
		logic                reg_write;
		logic                mem_read;
		logic                mem_write;
		logic                branch;
		logic                jump;
		mips_pkg::sel2_t     mem_to_reg;
		logic                chk_alu;
		mips_pkg::word_t     alu;
		logic                zero;
		logic                chk_wreg;
		mips_pkg::reg_addr_t wreg;
		mips_pkg::word_t     store;
		mips_pkg::word_t     pc4;
		mips_pkg::word_t     baddr;
		mips_pkg::word_t     jaddr;
	} ex_expect_t;

	logic                clk;
	logic                rst;
	mips_pkg::word_t     instr;
	mips_pkg::word_t     pc_plus4;
	logic                branch_flush;
	logic                wb_reg_write;
	mips_pkg::reg_addr_t wb_rd;
	mips_pkg::word_t     wb_data;
	logic                stall;
	logic                ex_reg_write;
	mips_pkg::sel2_t     ex_mem_to_reg;
	logic                ex_mem_read;
	logic                ex_mem_write;
	logic                ex_branch;
	logic                ex_jump;
	mips_pkg::word_t     ex_alu_result;
	logic                ex_zero;
	mips_pkg::reg_addr_t ex_write_reg;
	mips_pkg::word_t     ex_store_data;
	mips_pkg::word_t     ex_branch_addr;
	mips_pkg::word_t     ex_jump_addr;
	mips_pkg::word_t     ex_pc_plus4;

	// register model, only the write-back port changes it
	mips_pkg::word_t     model [32];
	ex_expect_t          next_ex;
	ex_expect_t          cur_ex;
	logic                exp_stall;
	logic                chk_stall;
	logic                rst_window;
	// load sitting in id/ex and its rt field
	logic                idex_load;
	mips_pkg::reg_addr_t idex_rt;
	mips_pkg::word_t     pc;
	int                  stalls;
	int                  cycles = 0;
	integer              seed;

	decode_execute #(
		.REG_COUNT (32)
	) i_decode_execute (
		.clk            (clk),
		.rst            (rst),
		.instr          (instr),
		.pc_plus4       (pc_plus4),
		.branch_flush   (branch_flush),
		.wb_reg_write   (wb_reg_write),
		.wb_rd          (wb_rd),
		.wb_data        (wb_data),
		.stall          (stall),
		.ex_reg_write   (ex_reg_write),
		.ex_mem_to_reg  (ex_mem_to_reg),
		.ex_mem_read    (ex_mem_read),
		.ex_mem_write   (ex_mem_write),
		.ex_branch      (ex_branch),
		.ex_jump        (ex_jump),
		.ex_alu_result  (ex_alu_result),
		.ex_zero        (ex_zero),
		.ex_write_reg   (ex_write_reg),
		.ex_store_data  (ex_store_data),
		.ex_branch_addr (ex_branch_addr),
		.ex_jump_addr   (ex_jump_addr),
		.ex_pc_plus4    (ex_pc_plus4)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("FAIL %s got %h expected %h", name, got, want);
		$display("SOME TESTS FAILED");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic report_error(input string what);
		$display("error: %s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", what);
	endtask

	// run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			report_error("run did not finish within the cycle limit");
	end

	// reset and the first cycle after it
	a_reset: assert property (@(posedge clk) rst_window |-> !(ex_reg_write || ex_mem_read
		|| ex_mem_write || ex_branch || ex_jump || stall || ex_mem_to_reg != 2'b00))
		else report_error("control outputs or stall not zero around reset");

	a_stall: assert property (@(posedge clk) chk_stall |-> stall == exp_stall)
		else report_mismatch("stall", 32'($sampled(stall)), 32'(exp_stall));

	// control group
	a_reg_write: assert property (@(posedge clk)
		cur_ex.valid |-> ex_reg_write == cur_ex.reg_write)
		else report_mismatch("ex_reg_write", 32'($sampled(ex_reg_write)),
			32'(cur_ex.reg_write));
	a_mem_read: assert property (@(posedge clk)
		cur_ex.valid |-> ex_mem_read == cur_ex.mem_read)
		else report_mismatch("ex_mem_read", 32'($sampled(ex_mem_read)), 32'(cur_ex.mem_read));
	a_mem_write: assert property (@(posedge clk)
		cur_ex.valid |-> ex_mem_write == cur_ex.mem_write)
		else report_mismatch("ex_mem_write", 32'($sampled(ex_mem_write)),
			32'(cur_ex.mem_write));
	a_branch: assert property (@(posedge clk) cur_ex.valid |-> ex_branch == cur_ex.branch)
		else report_mismatch("ex_branch", 32'($sampled(ex_branch)), 32'(cur_ex.branch));
	a_jump: assert property (@(posedge clk) cur_ex.valid |-> ex_jump == cur_ex.jump)
		else report_mismatch("ex_jump", 32'($sampled(ex_jump)), 32'(cur_ex.jump));
	a_mem_to_reg: assert property (@(posedge clk)
		cur_ex.valid |-> ex_mem_to_reg == cur_ex.mem_to_reg)
		else report_mismatch("ex_mem_to_reg", 32'($sampled(ex_mem_to_reg)),
			32'(cur_ex.mem_to_reg));

	// results, only where the instruction defines them
	a_alu: assert property (@(posedge clk)
		cur_ex.valid && cur_ex.chk_alu |-> ex_alu_result == cur_ex.alu)
		else report_mismatch("ex_alu_result", $sampled(ex_alu_result), cur_ex.alu);
	a_zero: assert property (@(posedge clk)
		cur_ex.valid && cur_ex.chk_alu |-> ex_zero == cur_ex.zero)
		else report_mismatch("ex_zero", 32'($sampled(ex_zero)), 32'(cur_ex.zero));
	a_write_reg: assert property (@(posedge clk)
		cur_ex.valid && cur_ex.chk_wreg |-> ex_write_reg == cur_ex.wreg)
		else report_mismatch("ex_write_reg", 32'($sampled(ex_write_reg)), 32'(cur_ex.wreg));

	// data fields pass even through a bubble
	a_store: assert property (@(posedge clk) cur_ex.valid |-> ex_store_data == cur_ex.store)
		else report_mismatch("ex_store_data", $sampled(ex_store_data), cur_ex.store);
	a_pc4: assert property (@(posedge clk) cur_ex.valid |-> ex_pc_plus4 == cur_ex.pc4)
		else report_mismatch("ex_pc_plus4", $sampled(ex_pc_plus4), cur_ex.pc4);
	a_baddr: assert property (@(posedge clk) cur_ex.valid |-> ex_branch_addr == cur_ex.baddr)
		else report_mismatch("ex_branch_addr", $sampled(ex_branch_addr), cur_ex.baddr);
	a_jaddr: assert property (@(posedge clk) cur_ex.valid |-> ex_jump_addr == cur_ex.jaddr)
		else report_mismatch("ex_jump_addr", $sampled(ex_jump_addr), cur_ex.jaddr);

	function automatic mips_pkg::word_t r_format(input mips_pkg::funct_t fn,
			input mips_pkg::reg_addr_t rd, input mips_pkg::reg_addr_t rs,
			input mips_pkg::reg_addr_t rt);
		return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic mips_pkg::word_t i_format(input mips_pkg::opcode_t op,
			input mips_pkg::reg_addr_t rt, input mips_pkg::reg_addr_t rs,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_pkg::word_t j_format(input mips_pkg::opcode_t op,
			input logic [25:0] target);
		return {op, target};
	endfunction

	// controls and results of an instruction that is not bubbled
	task automatic expect_result(input mips_pkg::word_t ins, input mips_pkg::word_t a,
			input mips_pkg::word_t b, input mips_pkg::word_t imm);
		next_ex.chk_alu = 1'b1;
		next_ex.chk_wreg = 1'b1;
		next_ex.wreg = ins[20:16];
		case (ins[31:26])
			mips_pkg::OP_RTYPE: begin
				next_ex.reg_write = 1'b1;
				next_ex.wreg = ins[15:11];
				case (ins[5:0])
					mips_pkg::FN_SUB: next_ex.alu = a - b;
					mips_pkg::FN_AND: next_ex.alu = a & b;
					mips_pkg::FN_OR:  next_ex.alu = a | b;
					mips_pkg::FN_SLT: next_ex.alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:          next_ex.alu = a + b;
				endcase
			end
			mips_pkg::OP_ADDI: begin
				next_ex.reg_write = 1'b1;
				next_ex.alu = a + imm;
			end
			mips_pkg::OP_LW: begin
				next_ex.reg_write = 1'b1;
				next_ex.mem_read = 1'b1;
				next_ex.mem_to_reg = 2'b01;
				next_ex.alu = a + imm;
			end
			mips_pkg::OP_SW: begin
				next_ex.mem_write = 1'b1;
				next_ex.chk_wreg = 1'b0;
				next_ex.alu = a + imm;
			end
			mips_pkg::OP_BEQ: begin
				next_ex.branch = 1'b1;
				next_ex.chk_wreg = 1'b0;
				next_ex.alu = a - b;
			end
			mips_pkg::OP_JAL: begin
				// link into r31 from pc+4
				next_ex.jump = 1'b1;
				next_ex.reg_write = 1'b1;
				next_ex.mem_to_reg = 2'b10;
				next_ex.chk_alu = 1'b0;
				next_ex.wreg = 5'd31;
			end
			mips_pkg::OP_J: begin
				next_ex.jump = 1'b1;
				next_ex.chk_alu = 1'b0;
				next_ex.chk_wreg = 1'b0;
			end
			default: begin
				next_ex.chk_alu = 1'b0;
				next_ex.chk_wreg = 1'b0;
			end
		endcase
		// beq compares the registers directly
		if (ins[31:26] == mips_pkg::OP_BEQ)
			next_ex.zero = (a == b);
		else
			next_ex.zero = (next_ex.alu == 32'd0);
	endtask

	// one falling edge: drive if/id and write-back, predict stall and id/ex
	task automatic present(input mips_pkg::word_t ins, input logic flush, input logic we,
			input mips_pkg::reg_addr_t wrd, input mips_pkg::word_t wdata);
		mips_pkg::reg_addr_t rs;
		mips_pkg::reg_addr_t rt;
		mips_pkg::word_t     imm;
		logic                bubble;
		@(negedge clk);
		// id/ex now holds the previous prediction
		cur_ex = next_ex;
		instr = ins;
		pc_plus4 = pc;
		branch_flush = flush;
		wb_reg_write = we;
		wb_rd = wrd;
		wb_data = wdata;
		rs = ins[25:21];
		rt = ins[20:16];
		// reads in this cycle already see the write
		if (we && wrd != 5'd0)
			model[wrd] = wdata;
		exp_stall = idex_load && idex_rt != 5'd0 && (idex_rt == rs || idex_rt == rt);
		chk_stall = 1'b1;
		if (exp_stall)
			stalls++;
		bubble = exp_stall || flush;
		imm = 32'($signed(ins[15:0]));
		next_ex = '0;
		next_ex.valid = 1'b1;
		next_ex.store = model[rt];
		next_ex.pc4 = pc;
		next_ex.baddr = pc + (imm << 2);
		// top nibble of pc+4, then the word target as a byte address
		next_ex.jaddr = (pc & 32'hf000_0000) | (32'(ins[25:0]) * 32'd4);
		if (!bubble)
			expect_result(ins, model[rs], model[rt], imm);
		idex_load = !bubble && ins[31:26] == mips_pkg::OP_LW;
		idex_rt = rt;
	endtask

	// hold the instruction for as long as the stall lasts
	task automatic issue(input mips_pkg::word_t ins, input logic flush, input logic we,
			input mips_pkg::reg_addr_t wrd, input mips_pkg::word_t wdata);
		present(ins, flush, we, wrd, wdata);
		if (exp_stall)
			present(ins, flush, 1'b0, 5'd0, 32'd0);
		pc = pc + 32'd4;
	endtask

	task automatic send(input mips_pkg::word_t ins);
		issue(ins, 1'b0, 1'b0, 5'd0, 32'd0);
	endtask

	initial begin
		int                  kind;
		mips_pkg::reg_addr_t rd;
		mips_pkg::reg_addr_t rs;
		mips_pkg::reg_addr_t rt;
		mips_pkg::reg_addr_t wrd;
		mips_pkg::word_t     ins;
		logic                we;
		seed = 36644;
		rst = 1'b1;
		instr = NOP;
		pc_plus4 = '0;
		branch_flush = 1'b0;
		wb_reg_write = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		rst_window = 1'b0;
		chk_stall = 1'b0;
		exp_stall = 1'b0;
		idex_load = 1'b0;
		idex_rt = '0;
		next_ex = '0;
		cur_ex = '0;
		stalls = 0;
		pc = 32'h8040_0000;
		for (int i = 0; i < 32; i++)
			model[i] = '0;

		// 8 cycles of reset, checked up to one cycle after release
		@(negedge clk);
		rst_window = 1'b1;
		repeat (7) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		rst_window = 1'b0;

		// preload, r4 mirrors r1 for a taken beq
		issue(NOP, 1'b0, 1'b1, 5'd1, 32'h0000_1234);
		issue(NOP, 1'b0, 1'b1, 5'd2, 32'hffff_ff00);
		issue(NOP, 1'b0, 1'b1, 5'd3, 32'h7fff_fff0);
		issue(NOP, 1'b0, 1'b1, 5'd4, 32'h0000_1234);

		// alu operations
		send(r_format(mips_pkg::FN_ADD, 5'd5, 5'd1, 5'd2));
		send(r_format(mips_pkg::FN_SUB, 5'd6, 5'd1, 5'd2));
		send(r_format(mips_pkg::FN_AND, 5'd7, 5'd1, 5'd3));
		send(r_format(mips_pkg::FN_OR, 5'd8, 5'd2, 5'd3));
		send(r_format(mips_pkg::FN_SLT, 5'd9, 5'd2, 5'd1));
		send(r_format(mips_pkg::FN_SLT, 5'd10, 5'd3, 5'd2));
		send(i_format(mips_pkg::OP_ADDI, 5'd11, 5'd3, 16'hfff0));
		// r13 written and read in the same cycle
		issue(r_format(mips_pkg::FN_ADD, 5'd12, 5'd1, 5'd13), 1'b0, 1'b1, 5'd13,
			32'h0000_0100);

		// load-use through rs, then through rt
		send(i_format(mips_pkg::OP_LW, 5'd14, 5'd1, 16'h0004));
		send(r_format(mips_pkg::FN_SUB, 5'd15, 5'd14, 5'd2));
		send(i_format(mips_pkg::OP_LW, 5'd16, 5'd2, 16'hfffc));
		send(r_format(mips_pkg::FN_AND, 5'd17, 5'd3, 5'd16));

		// flushed store keeps its data fields
		issue(i_format(mips_pkg::OP_SW, 5'd3, 5'd1, 16'h0008), 1'b1, 1'b0, 5'd0, 32'd0);

		// branch, store and jumps
		send(i_format(mips_pkg::OP_BEQ, 5'd4, 5'd1, 16'h0010));
		send(i_format(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'hfffd));
		send(i_format(mips_pkg::OP_SW, 5'd3, 5'd2, 16'h000c));
		send(j_format(mips_pkg::OP_JAL, 26'h0123456));
		send(j_format(mips_pkg::OP_J, 26'h3ffffff));

		// random mix on r0..r7 so load-use hazards come up often
		repeat (60) begin
			kind = {$random(seed)} % 11;
			rd = 5'($random(seed) & 7);
			rs = 5'($random(seed) & 7);
			rt = 5'($random(seed) & 7);
			case (kind)
				0: ins = r_format(mips_pkg::FN_ADD, rd, rs, rt);
				1: ins = r_format(mips_pkg::FN_SUB, rd, rs, rt);
				2: ins = r_format(mips_pkg::FN_AND, rd, rs, rt);
				3: ins = r_format(mips_pkg::FN_OR, rd, rs, rt);
				4: ins = r_format(mips_pkg::FN_SLT, rd, rs, rt);
				5: ins = i_format(mips_pkg::OP_ADDI, rt, rs, 16'($random(seed)));
				6: ins = i_format(mips_pkg::OP_LW, rt, rs, 16'($random(seed)));
				7: ins = i_format(mips_pkg::OP_SW, rt, rs, 16'($random(seed)));
				8: ins = i_format(mips_pkg::OP_BEQ, rt, rs, 16'($random(seed)));
				9: ins = j_format(mips_pkg::OP_J, 26'($random(seed)));
				default: ins = j_format(mips_pkg::OP_JAL, 26'($random(seed)));
			endcase
			// occasional write-back alongside the issue
			we = ($random(seed) & 3) == 0;
			wrd = 5'($random(seed) & 7);
			issue(ins, 1'b0, we, wrd, $random(seed));
		end

		// last instruction reaches the checks, then stop checking
		@(negedge clk);
		cur_ex = next_ex;
		chk_stall = 1'b0;
		@(negedge clk);
		cur_ex.valid = 1'b0;

		if (stalls == 0)
			report_error("no load-use stall came up during the run");
		else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
